//--- build.f
+incdir+verif
hdl/pat_pkg.sv
hdl/pat_exec_if.sv
hdl/pat_fetch.sv
hdl/pat_regfile.sv
hdl/pat_decoder.sv
hdl/pat_alu.sv
hdl/pat_execute.sv
hdl/pat_core.sv
verif/pat_tb.sv

//--- verif/pat_tb_prog.svh
// test program built one word at a time through add_instr
// i8 word arguments in order rn fieldp cond field_op opcode imm8
// i3 word arguments in order rn fieldp cond field_op opcode and the low nibble of imm8
task automatic load_program();
	// i8 chains with back-to-back dependent pairs
	add_instr(make_instr(3'd1, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h35));
	add_instr(make_instr(3'd2, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h0c));
	add_instr(make_instr(3'd1, 5'd0, COND_AL, 1'b0, OP_ORR, 8'h02));  // r1 |= r2
	add_instr(make_instr(3'd1, 5'd0, COND_AL, 1'b0, OP_ADDI, 8'h91));
	add_instr(make_i3(3'd1, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd1, 5'd0, COND_AL, 1'b0, OP_SUBR, 8'h02));
	add_instr(make_instr(3'd1, 5'd0, COND_AL, 1'b0, OP_ANDI, 8'h5f)); // clears bits of r1
	add_instr(make_i3(3'd1, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	// shifts, NOT and IN
	add_instr(make_instr(3'd3, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h96));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHLOI, 4'h2));   // one fill
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd3, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h96));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_ASRI, 4'h1));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd4, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h03));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_ASRR, 4'h4));    // sign copied in
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHRZR, 4'h4));   // by r4
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHLZR, 4'h4));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHLOR, 4'h4));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHLZI, 4'h1));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_SHRZI, 4'h2));
	add_instr(make_i0(3'd3, COND_AL, OP_NOT));
	add_instr(make_i3(3'd3, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_IN, 4'h1));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_IN, 4'h2));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_IN, 4'h4));
	add_instr(make_i3(3'd5, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	// flags, conditions and branches
	add_instr(make_instr(3'd6, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h00));
	add_instr(make_i0(3'd6, COND_AL, OP_TEST));
	add_instr(make_i3(3'd1, 5'd0, COND_Z, 1'b0, OP_OUT, 4'h0));     // taken
	add_instr(make_i3(3'd2, 5'd0, COND_NZ, 1'b0, OP_OUT, 4'h0));    // skipped
	add_instr(make_i3(3'd4, 5'd0, COND_N, 1'b0, OP_OUT, 4'h0));     // skipped
	add_instr(make_instr(3'd6, 5'd0, COND_AL, 1'b0, OP_LDI, 8'h80));
	add_instr(make_i0(3'd6, COND_AL, OP_TEST));
	add_instr(make_i3(3'd3, 5'd0, COND_N, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd0, 5'd0, COND_NZ, 1'b0, OP_BF, 8'h03)); // over two
	add_instr(make_i3(3'd1, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd2, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_i3(3'd2, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd0, 5'd0, COND_Z, 1'b0, OP_BF, 8'h05));  // falls through
	// field buffers
	add_instr(make_i3(3'd0, 5'd0, COND_AL, 1'b0, OP_SETB, 4'hd));   // high buffer with bufp 5
	add_instr(make_instr(3'd1, 5'd7, COND_AL, 1'b1, OP_ADDR, 8'h00));
	add_instr(make_i3(3'd2, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
	add_instr(make_instr(3'd2, 5'd7, COND_AL, 1'b1, OP_ORI, 8'h00));
	add_instr(make_i3(3'd0, 5'd0, COND_AL, 1'b0, OP_SETB, 4'h2));   // low buffer with bufp 2
	add_instr(make_instr(3'd1, 5'd3, COND_AL, 1'b1, OP_SUBI, 8'h00));
	add_instr(make_i3(3'd3, 5'd9, COND_AL, 1'b1, OP_SHLOI, 4'h0));
	add_instr(make_i3(3'd1, 5'd0, COND_AL, 1'b0, OP_OUT, 4'h0));
endtask

//--- verif/pat_tb.sv
`timescale 1ns/1ps

module pat_tb
	import pat_pkg::*;
();

	logic clk, reset;
	logic [PC_W-1:0] o_pc;
	logic [INSTR_W-1:0] i_instruction;
	logic o_jump, o_out_valid, o_field_we_low, o_field_we_high;
	logic [DATA_W-1:0] i_in0, i_in1, i_in2, o_out, i_field_low, i_field_high, o_field_data;
	logic [FIELDP_W-1:0] o_fieldp, o_field_wp;
	logic [BUFP_W-1:0] o_bufp;

	logic [INSTR_W-1:0] prog [64];
	int prog_len = 0;
	logic [DATA_W-1:0] fmem_low [32], fmem_high [32]; // field memory seen by the DUT
	integer seed = 32'h87a4;
	logic [DATA_W-1:0] exp_out [$];
	logic [16:0] exp_field [$];  // {high, wp, data, bufp}
	logic [PC_W-1:0] exp_jump [$];
	int n_out, n_field, n_jump, seen_out, seen_field, seen_jump;
	int executed, limit, cycles, val_errs, cnt_errs;

	pat_core pat_core_i (.*);

	assign i_instruction = (o_pc < prog_len) ? prog[o_pc] : INSTR_NOP;
	assign i_field_low   = fmem_low[o_fieldp];
	assign i_field_high  = fmem_high[o_fieldp];

	function automatic logic [INSTR_W-1:0] make_instr(logic [2:0] rn, logic [4:0] fp,
		pat_cond_e cond, logic fop, logic [3:0] op, logic [7:0] imm);
		return {rn, fp, cond, fop, op, imm};
	endfunction

	function automatic logic [INSTR_W-1:0] make_i3(logic [2:0] rn, logic [4:0] fp,
		pat_cond_e cond, logic fop, pat_op_i3_e op, logic [3:0] lo);
		return make_instr(rn, fp, cond, fop, I3_PREFIX, {op, lo});
	endfunction

	function automatic logic [INSTR_W-1:0] make_i0(logic [2:0] rn, pat_cond_e cond,
		pat_op_i0_e op);
		return make_instr(rn, 5'd0, cond, 1'b0, I3_PREFIX, {I0_PREFIX, op});
	endfunction

	task automatic add_instr(logic [INSTR_W-1:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	`include "pat_tb_prog.svh"

	// ==============================
	// instruction level reference model
	// ==============================
	task automatic run_model();
		logic [7:0] regs [8], mlow [32], mhigh [32], a, b, fv, res, imm;
		logic z, n, ok, wr, bhigh;
		logic [2:0] rn, bufp, sh;
		logic [3:0] op;
		int pc;
		z = 0;
		n = 0;
		bhigh = 0;
		bufp = 0;
		pc = 0;
		mlow = fmem_low;
		mhigh = fmem_high;
		while (pc >= 0 && pc < prog_len)
		begin
			{rn, imm} = {prog[pc][22:20], prog[pc][7:0]};
			ok = (prog[pc][14:13] == 0) ? z : (prog[pc][14:13] == 1) ? !z :
				(prog[pc][14:13] == 2) ? n : 1'b1;
			a = regs[rn];
			fv = bhigh ? mhigh[prog[pc][19:15]] : mlow[prog[pc][19:15]];
			wr = 0;
			res = 0;
			executed++;
			if (prog[pc][11:8] != 4'hf)
			begin
				op = prog[pc][11:8];
				b = (op < 8 && op[0]) ? regs[imm[2:0]] : imm;
				b = prog[pc][12] ? fv : b;
				wr = (op <= 8);
				case (op)
					0, 1: res = a | b;
					2, 3: res = a & b;
					4, 5: res = a + b;
					6, 7: res = a - b;
					8: res = b;
					13: if (ok) exp_jump.push_back(PC_W'(pc + int'($signed(imm))));
					default: ;
				endcase
				if (op == 13 && ok)
					pc = pc + int'($signed(imm)) - 1;
			end
			else if (imm[7:4] != 4'hf)
			begin
				op = imm[7:4];
				b = (op < 8 && op[0]) ? regs[imm[2:0]] : {5'd0, imm[2:0]};
				b = prog[pc][12] ? fv : b;
				sh = b[2:0];
				wr = (op <= 8);
				case (op)
					0, 1: res = a << sh;
					2, 3: res = (a << sh) | ((8'd1 << sh) - 8'd1); // ones shifted in
					4, 5: res = a >> sh;
					6, 7: res = 8'({{8{a[7]}}, a} >> sh);           // sign extended first
					8: res = (imm[2:0] == 3'b010) ? i_in1 : (imm[2:0] == 3'b100) ? i_in2 : i_in0;
					11: if (ok) exp_out.push_back(a);
					12: if (ok) {bhigh, bufp} = imm[3:0];
					default: ;
				endcase
			end
			else if (imm[3:0] == 0)
			begin
				res = ~a;
				wr = 1;
			end
			else if (imm[3:0] == 2 && ok)
				{z, n} = {a == 0, a[7]};
			if (ok && wr && prog[pc][12])
			begin
				exp_field.push_back({bhigh, prog[pc][19:15], res, bufp});
				if (bhigh) mhigh[prog[pc][19:15]] = res;
				else mlow[prog[pc][19:15]] = res;
			end
			else if (ok && wr)
				regs[rn] = res;
			pc++;
		end
	endtask

	initial
	begin
		clk = 0;
		forever #4 clk = ~clk;
	end

	// field memory takes the write strobes
	always @(posedge clk)
	begin
		if (o_field_we_low) fmem_low[o_field_wp] <= o_field_data;
		if (o_field_we_high) fmem_high[o_field_wp] <= o_field_data;
		if (!reset) cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout after %0d cycles, strobes still missing", cycles);
			$display("value errors %0d, count errors %0d", val_errs, cnt_errs);
			$display("Test failures found");
			$finish;
		end
	end

	// ==============================
	// checks sampled mid cycle
	// ==============================
	always @(negedge clk)
	begin : check
		logic [16:0] f;
		if (reset || cycles == 0)
		begin
			// reset values hold up to the first edge after release
			a_reset: assert (o_pc == 0 && !o_jump && !o_out_valid && !o_field_we_low
				&& !o_field_we_high)
			else
			begin
				val_errs++;
				$display("ERROR reset state: o_pc %h o_jump %h o_out_valid %h", o_pc, o_jump,
					o_out_valid);
				$display("ERROR reset state: o_field_we_low %h o_field_we_high %h",
					o_field_we_low, o_field_we_high);
			end
		end
		else
		begin
			if (o_out_valid)
			begin
				seen_out++;
				if (exp_out.size() == 0)
					$display("OUT strobe seen with no value left in the model");
				else
				begin
					a_out: assert (o_out == exp_out[0])
					else
					begin
						val_errs++;
						$display("ERROR o_out: got %h expected %h", o_out, exp_out[0]);
					end
					void'(exp_out.pop_front());
				end
			end
			if (o_field_we_low || o_field_we_high)
			begin
				seen_field++;
				if (exp_field.size() == 0)
					$display("field write seen with none left in the model");
				else
				begin
					f = exp_field.pop_front();
					a_field: assert ({o_field_we_high, o_field_wp, o_field_data, o_bufp} == f)
					else
					begin
						val_errs++;
						$display("ERROR field write {we_high,wp,data,o_bufp}: got %h expected %h",
							{o_field_we_high, o_field_wp, o_field_data, o_bufp}, f);
					end
				end
			end
			if (o_jump)
			begin
				seen_jump++;
				if (exp_jump.size() == 0)
					$display("jump seen with no taken branch left in the model");
				else
				begin
					a_jump: assert (o_pc == exp_jump[0])
					else
					begin
						val_errs++;
						$display("ERROR o_pc: got %h expected %h", o_pc, exp_jump[0]);
					end
					void'(exp_jump.pop_front());
				end
			end
		end
	end

	initial
	begin
		reset = 1;
		{i_in0, i_in1, i_in2} = '0;
		for (int i = 0; i < 32; i++)
		begin
			fmem_low[i]  = $random(seed);
			fmem_high[i] = $random(seed);
		end
		i_in0 = $random(seed);
		i_in1 = $random(seed);
		i_in2 = $random(seed);
		load_program();
		run_model();
		{n_out, n_field, n_jump} = {exp_out.size(), exp_field.size(), exp_jump.size()};
		limit = 4 * executed + 50;
		repeat (16) @(posedge clk);
		#1 reset = 0;
		wait (seen_out >= n_out && seen_field >= n_field && seen_jump >= n_jump);
		repeat (10) @(posedge clk); // catch stray strobes
		a_counts: assert (seen_out == n_out && seen_field == n_field && seen_jump == n_jump)
		else
		begin
			cnt_errs++;
			$display("strobes seen out %0d field %0d jump %0d but model has %0d %0d %0d",
				seen_out, seen_field, seen_jump, n_out, n_field, n_jump);
		end
		$display("value errors %0d, count errors %0d", val_errs, cnt_errs);
		if (val_errs == 0 && cnt_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- hdl/pat_core.sv
`timescale 1ns/1ps

module pat_core
	import pat_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	output logic [PC_W-1:0]     o_pc,
	input  logic [INSTR_W-1:0]  i_instruction,
	output logic                o_jump,
	input  logic [DATA_W-1:0]   i_in0,
	input  logic [DATA_W-1:0]   i_in1,
	input  logic [DATA_W-1:0]   i_in2,
	output logic [DATA_W-1:0]   o_out,
	output logic                o_out_valid,
	output logic [FIELDP_W-1:0] o_fieldp,
	input  logic [DATA_W-1:0]   i_field_low,
	input  logic [DATA_W-1:0]   i_field_high,
	output logic                o_field_we_low,
	output logic                o_field_we_high,
	output logic [FIELDP_W-1:0] o_field_wp,
	output logic [DATA_W-1:0]   o_field_data,
	output logic [BUFP_W-1:0]   o_bufp
);

	logic [INSTR_W-1:0] instr;
	logic [PC_W-1:0]    instr_pc;
	logic               instr_valid;
	logic               redirect;
	logic [PC_W-1:0]    redirect_pc;
	logic [REG_AW-1:0]  rd_addr_a, rd_addr_b;
	logic [DATA_W-1:0]  rd_a, rd_b;
	logic               rf_we;
	logic [REG_AW-1:0]  rf_wr_addr;
	logic [DATA_W-1:0]  rf_wr_data;

	pat_exec_if exec_bus ();

	// ============================
	// stages
	// ============================
	pat_fetch fetch_i (.clk, .reset, .i_redirect(redirect), .i_redirect_pc(redirect_pc),
		.i_instruction, .o_pc, .o_instr(instr), .o_instr_pc(instr_pc),
		.o_instr_valid(instr_valid));

	pat_decoder decoder_i (.clk, .reset, .i_instr(instr), .i_instr_pc(instr_pc),
		.i_instr_valid(instr_valid), .i_redirect(redirect), .i_in0, .i_in1, .i_in2,
		.o_rf_rd_addr_a(rd_addr_a), .o_rf_rd_addr_b(rd_addr_b), .i_rf_rd_a(rd_a),
		.i_rf_rd_b(rd_b), .o_exec(exec_bus));

	pat_regfile regfile_i (.clk, .i_rd_addr_a(rd_addr_a), .i_rd_addr_b(rd_addr_b),
		.o_rd_a(rd_a), .o_rd_b(rd_b), .i_we(rf_we), .i_wr_addr(rf_wr_addr),
		.i_wr_data(rf_wr_data));

	pat_execute execute_i (.clk, .reset, .i_exec(exec_bus), .i_field_low, .i_field_high,
		.o_fieldp, .o_rf_we(rf_we), .o_rf_wr_addr(rf_wr_addr), .o_rf_wr_data(rf_wr_data),
		.o_redirect(redirect), .o_redirect_pc(redirect_pc), .o_jump, .o_out, .o_out_valid,
		.o_field_we_low, .o_field_we_high, .o_field_wp, .o_field_data, .o_bufp);

endmodule

//--- hdl/pat_execute.sv
`timescale 1ns/1ps

module pat_execute
	import pat_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	pat_exec_if.execute         i_exec,
	input  logic [DATA_W-1:0]   i_field_low,
	input  logic [DATA_W-1:0]   i_field_high,
	output logic [FIELDP_W-1:0] o_fieldp,       // field read address
	output logic                o_rf_we,
	output logic [REG_AW-1:0]   o_rf_wr_addr,
	output logic [DATA_W-1:0]   o_rf_wr_data,
	output logic                o_redirect,     // taken branch, to fetch and decode
	output logic [PC_W-1:0]     o_redirect_pc,
	output logic                o_jump,
	output logic [DATA_W-1:0]   o_out,
	output logic                o_out_valid,
	output logic                o_field_we_low,
	output logic                o_field_we_high,
	output logic [FIELDP_W-1:0] o_field_wp,
	output logic [DATA_W-1:0]   o_field_data,
	output logic [BUFP_W-1:0]   o_bufp
);

	pat_uop_t          uop;
	logic              flag_z, flag_n;
	logic              buf_high;   // high field buffer selected
	logic [DATA_W-1:0] field_val;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_y;
	logic [DATA_W-1:0] src_val;    // value seen by OUT and TEST
	logic              cond_ok;
	logic              take;       // valid and condition holds

	assign uop       = i_exec.uop;
	assign o_fieldp  = uop.fieldp; // pointer travels with the micro-op
	assign field_val = buf_high ? i_field_high : i_field_low;
	assign alu_b     = uop.field_op ? field_val : i_exec.operand_b;
	assign src_val   = uop.field_op ? field_val : i_exec.operand_a;

	pat_alu alu_i (.i_a(i_exec.operand_a), .i_b(alu_b), .i_op(uop.alu_op), .o_y(alu_y));

	// ============================
	// condition check
	// ============================
	always_comb
	begin
		case (uop.cond)
			COND_Z:  cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z;
			COND_N:  cond_ok = flag_n;
			default: cond_ok = 1'b1; // AL
		endcase
	end

	assign take = i_exec.valid && cond_ok;

	assign o_rf_we       = take && (uop.dest == DST_REG);
	assign o_rf_wr_addr  = uop.rn;
	assign o_rf_wr_data  = alu_y;
	assign o_redirect    = take && (uop.dest == DST_BRANCH);
	assign o_redirect_pc = uop.pc + {{(PC_W-DATA_W){uop.imm8[DATA_W-1]}}, uop.imm8}; // signed

	// ============================
	// commit of strobes and state
	// ============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flag_z          <= 1'b0;
			flag_n          <= 1'b0;
			buf_high        <= 1'b0;
			o_bufp          <= '0;
			o_jump          <= 1'b0;
			o_out_valid     <= 1'b0;
			o_field_we_low  <= 1'b0;
			o_field_we_high <= 1'b0;
		end
		else
		begin
			o_jump          <= o_redirect; // one cycle, alongside the new pc
			o_out_valid     <= take && (uop.dest == DST_OUT);
			o_field_we_low  <= take && (uop.dest == DST_FIELD) && !buf_high;
			o_field_we_high <= take && (uop.dest == DST_FIELD) && buf_high;
			if (take && uop.dest == DST_FLAGS)
			begin
				flag_z <= (src_val == '0);
				flag_n <= src_val[DATA_W-1];
			end
			if (take && uop.dest == DST_BUFSEL)
			begin
				buf_high <= uop.imm8[3];          // bit 3 picks the buffer
				o_bufp   <= uop.imm8[BUFP_W-1:0];
			end
		end
	end

	// payload beside the strobes
	always_ff @(posedge clk)
	begin
		if (uop.dest == DST_FIELD)
		begin
			o_field_wp   <= uop.fieldp; // write back where it was read
			o_field_data <= alu_y;
		end
		if (uop.dest == DST_OUT)
			o_out <= src_val;
	end

	a_one_field_we: assert property (@(posedge clk) disable iff (reset)
		!(o_field_we_low && o_field_we_high))
	else
		$error("both field write enables high");

	// decode has to drop the younger micro-op behind a taken branch
	a_redirect_squash: assert property (@(posedge clk) disable iff (reset)
		o_redirect |-> i_exec.valid ##1 !i_exec.valid)
	else
		$error("redirect without squash of the decode slot");

endmodule

//--- hdl/pat_alu.sv
`timescale 1ns/1ps

module pat_alu
	import pat_pkg::*;
(
	input  logic [DATA_W-1:0] i_a,   // register rn
	input  logic [DATA_W-1:0] i_b,   // register, immediate, port or field
	input  pat_alu_op_e       i_op,
	output logic [DATA_W-1:0] o_y
);

	logic [2:0]        shamt;     // shifts use the low three bits of b
	logic [DATA_W-1:0] shl_zero;
	logic [DATA_W-1:0] shl_one;
	logic [DATA_W-1:0] shr_zero;
	logic [DATA_W-1:0] shr_arith;
	logic [DATA_W-1:0] fill_mask; // ones in the vacated low bits

	assign shamt = i_b[2:0];

	// ============================
	// shifter
	// ============================
	assign shl_zero  = i_a << shamt;
	assign fill_mask = ~({DATA_W{1'b1}} << shamt);
	assign shl_one   = shl_zero | fill_mask;                  // left, one fill
	assign shr_zero  = i_a >> shamt;
	assign shr_arith = DATA_W'($signed(i_a) >>> shamt);      // sign bit copied in

	// ============================
	// function select
	// ============================
	always_comb
	begin
		case (i_op)
			ALU_OR:   o_y = i_a | i_b;
			ALU_AND:  o_y = i_a & i_b;
			ALU_NOT:  o_y = ~i_a;
			ALU_ADD:  o_y = i_a + i_b;     // wraps, no carry kept
			ALU_SUB:  o_y = i_a - i_b;
			ALU_PASS: o_y = i_b;
			ALU_SHLZ: o_y = shl_zero;
			ALU_SHLO: o_y = shl_one;
			ALU_SHRZ: o_y = shr_zero;
			ALU_ASR:  o_y = shr_arith;
			default:  o_y = i_b;
		endcase
	end

endmodule

//--- hdl/pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder
	import pat_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic [INSTR_W-1:0] i_instr,
	input  logic [PC_W-1:0]    i_instr_pc,
	input  logic               i_instr_valid,
	input  logic               i_redirect,      // squash this slot
	input  logic [DATA_W-1:0]  i_in0,
	input  logic [DATA_W-1:0]  i_in1,
	input  logic [DATA_W-1:0]  i_in2,
	output logic [REG_AW-1:0]  o_rf_rd_addr_a,
	output logic [REG_AW-1:0]  o_rf_rd_addr_b,
	input  logic [DATA_W-1:0]  i_rf_rd_a,
	input  logic [DATA_W-1:0]  i_rf_rd_b,
	pat_exec_if.decode         o_exec
);

	pat_instr_t        instr;
	logic              is_i8, is_i3;   // i0 when neither
	pat_op_i8_e        op8;
	pat_op_i3_e        op3;
	pat_op_i0_e        op0;
	pat_alu_op_e       alu_op;
	pat_dest_e         dest;
	logic              use_reg_b;      // R-form, b from register imm8[2:0]
	logic              b_is_in;        // IN, b from an input port
	logic [DATA_W-1:0] imm_val;
	logic [DATA_W-1:0] in_val;
	logic [DATA_W-1:0] b_val;

	assign instr = pat_instr_t'(i_instr);
	assign op8   = pat_op_i8_e'(instr.opcode_i8);
	assign op3   = pat_op_i3_e'(instr.imm8[7:4]);
	assign op0   = pat_op_i0_e'(instr.imm8[3:0]);
	assign is_i8 = (instr.opcode_i8 != I3_PREFIX);
	assign is_i3 = !is_i8 && (instr.imm8[7:4] != I0_PREFIX);

	assign o_rf_rd_addr_a = instr.rn;
	assign o_rf_rd_addr_b = instr.imm8[REG_AW-1:0];

	// ============================
	// format and opcode decode
	// ============================
	always_comb
	begin
		alu_op    = ALU_PASS;
		dest      = DST_NONE; // unknown codes fall out as NOP
		use_reg_b = 1'b0;
		b_is_in   = 1'b0;
		imm_val   = is_i8 ? instr.imm8 : {5'b0, instr.imm8[2:0]}; // i3 immediate is 3 bits
		if (is_i8)
		begin
			use_reg_b = instr.opcode_i8[0] && !instr.opcode_i8[3]; // odd codes below 8
			dest      = DST_REG;
			case (op8)
				OP_ORI, OP_ORR:   alu_op = ALU_OR;
				OP_ANDI, OP_ANDR: alu_op = ALU_AND;
				OP_ADDI, OP_ADDR: alu_op = ALU_ADD;
				OP_SUBI, OP_SUBR: alu_op = ALU_SUB;
				OP_LDI:           alu_op = ALU_PASS;
				OP_BF:            dest   = DST_BRANCH;
				default:          dest   = DST_NONE;
			endcase
		end
		else if (is_i3)
		begin
			use_reg_b = instr.imm8[4] && !instr.imm8[7]; // R-form shifts
			dest      = DST_REG;
			case (op3)
				OP_SHLZI, OP_SHLZR: alu_op = ALU_SHLZ;
				OP_SHLOI, OP_SHLOR: alu_op = ALU_SHLO;
				OP_SHRZI, OP_SHRZR: alu_op = ALU_SHRZ;
				OP_ASRI, OP_ASRR:   alu_op = ALU_ASR;
				OP_IN:              b_is_in = 1'b1;
				OP_OUT:             dest = DST_OUT;
				OP_SETB:            dest = DST_BUFSEL;
				default:            dest = DST_NONE;
			endcase
		end
		else
		begin
			case (op0)
				OP_NOT:
				begin
					alu_op = ALU_NOT;
					dest   = DST_REG;
				end
				OP_TEST: dest = DST_FLAGS;
				default: dest = DST_NONE; // OP_NOP and spare codes
			endcase
		end
		if (dest == DST_REG && instr.field_op)
			dest = DST_FIELD; // field ops write back to the field
	end

	// one-hot port select, anything else reads port 0
	always_comb
	begin
		case (instr.imm8[2:0])
			3'b010:  in_val = i_in1;
			3'b100:  in_val = i_in2;
			default: in_val = i_in0;
		endcase
	end

	assign b_val = b_is_in ? in_val : (use_reg_b ? i_rf_rd_b : imm_val);

	// ============================
	// decode pipeline register
	// ============================
	always_ff @(posedge clk)
	begin
		if (reset || i_redirect)
			o_exec.valid <= 1'b0;
		else
			o_exec.valid <= i_instr_valid;
	end

	always_ff @(posedge clk)
	begin
		o_exec.uop       <= '{alu_op: alu_op, dest: dest, rn: instr.rn, fieldp: instr.fieldp,
			cond: pat_cond_e'(instr.cond), field_op: instr.field_op, pc: i_instr_pc,
			imm8: instr.imm8};
		o_exec.operand_a <= i_rf_rd_a;
		o_exec.operand_b <= b_val;
	end

endmodule

//--- hdl/pat_regfile.sv
`timescale 1ns/1ps

module pat_regfile
	import pat_pkg::*;
(
	input  logic              clk,
	input  logic [REG_AW-1:0] i_rd_addr_a,
	input  logic [REG_AW-1:0] i_rd_addr_b,
	output logic [DATA_W-1:0] o_rd_a,
	output logic [DATA_W-1:0] o_rd_b,
	input  logic              i_we,       // commit from execute
	input  logic [REG_AW-1:0] i_wr_addr,
	input  logic [DATA_W-1:0] i_wr_data
);

	logic [DATA_W-1:0] regs [1 << REG_AW];

	always_ff @(posedge clk)
	begin
		if (i_we)
			regs[i_wr_addr] <= i_wr_data;
	end

	// bypass, decode sees the value being committed this very cycle
	assign o_rd_a = (i_we && i_wr_addr == i_rd_addr_a) ? i_wr_data : regs[i_rd_addr_a];
	assign o_rd_b = (i_we && i_wr_addr == i_rd_addr_b) ? i_wr_data : regs[i_rd_addr_b];

	// an X committed here would be forwarded and spread through later results
	a_wr_data_known: assert property (@(posedge clk) i_we |-> !$isunknown({i_wr_addr, i_wr_data}))
	else
		$error("regfile write of unknown data to r%0d", i_wr_addr);

endmodule

//--- hdl/pat_fetch.sv
`timescale 1ns/1ps

module pat_fetch
	import pat_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               i_redirect,     // taken branch from execute
	input  logic [PC_W-1:0]    i_redirect_pc,
	input  logic [INSTR_W-1:0] i_instruction,  // combinational answer to o_pc
	output logic [PC_W-1:0]    o_pc,
	output logic [INSTR_W-1:0] o_instr,
	output logic [PC_W-1:0]    o_instr_pc,
	output logic               o_instr_valid
);

	logic [PC_W-1:0] pc; // address on the fetch port this cycle

	assign o_pc = pc;

	// ============================
	// program counter and fetch register
	// ============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc            <= '0;
			o_instr       <= INSTR_NOP;
			o_instr_valid <= 1'b0;
		end
		else if (i_redirect)
		begin
			pc            <= i_redirect_pc; // jump target goes out next cycle
			o_instr       <= INSTR_NOP;     // squash the word in flight
			o_instr_valid <= 1'b0;
		end
		else
		begin
			pc            <= pc + PC_W'(1);
			o_instr       <= i_instruction;
			o_instr_valid <= 1'b1;
		end
	end

	// address travels with its word, used for branch targets
	always_ff @(posedge clk)
	begin
		o_instr_pc <= pc;
	end

endmodule

//--- hdl/pat_exec_if.sv
`timescale 1ns/1ps

// decoded micro-op with its operands, decode stage to execute stage
interface pat_exec_if import pat_pkg::*; ();

	logic              valid;     // real micro-op this cycle
	pat_uop_t          uop;
	logic [DATA_W-1:0] operand_a; // register rn
	logic [DATA_W-1:0] operand_b; // register, immediate or input port

	// decode produces
	modport decode
	(
		output valid,
		output uop,
		output operand_a,
		output operand_b
	);

	// execute consumes every valid micro-op on arrival, no back-pressure
	modport execute
	(
		input valid,
		input uop,
		input operand_a,
		input operand_b
	);

endinterface

//--- hdl/pat_pkg.sv
package pat_pkg;

	// ============================
	// widths
	// ============================
	localparam int PC_W     = 10; // instruction address
	localparam int INSTR_W  = 23;
	localparam int DATA_W   = 8;
	localparam int REG_AW   = 3;  // eight registers
	localparam int FIELDP_W = 5;  // 32 field entries per buffer
	localparam int BUFP_W   = 3;

	// format prefixes, i8 code 15 opens i3 space and i3 code 15 opens i0 space
	localparam logic [3:0] I3_PREFIX = 4'hf;
	localparam logic [3:0] I0_PREFIX = 4'hf;

	// rn 0, fieldp 0, cond AL, i0 NOP
	localparam logic [INSTR_W-1:0] INSTR_NOP = 23'h006fff;

	// ============================
	// instruction layout
	// ============================
	typedef struct packed {
		logic [REG_AW-1:0]   rn;        // source and destination register
		logic [FIELDP_W-1:0] fieldp;    // field pointer
		logic [1:0]          cond;
		logic                field_op;  // operate on the field instead of rn
		logic [3:0]          opcode_i8;
		logic [7:0]          imm8;      // i3 opcode in [7:4], i0 opcode in [3:0]
	} pat_instr_t;

	typedef enum logic [3:0] {
		OP_ORI = 4'd0, OP_ORR = 4'd1, OP_ANDI = 4'd2, OP_ANDR = 4'd3,
		OP_ADDI = 4'd4, OP_ADDR = 4'd5, OP_SUBI = 4'd6, OP_SUBR = 4'd7,
		OP_LDI = 4'd8, OP_BF = 4'd13
	} pat_op_i8_e;

	typedef enum logic [3:0] {
		OP_SHLZI = 4'd0, OP_SHLZR = 4'd1, OP_SHLOI = 4'd2, OP_SHLOR = 4'd3,
		OP_SHRZI = 4'd4, OP_SHRZR = 4'd5, OP_ASRI = 4'd6, OP_ASRR = 4'd7,
		OP_IN = 4'd8, OP_OUT = 4'd11, OP_SETB = 4'd12
	} pat_op_i3_e;

	typedef enum logic [3:0] {
		OP_NOT = 4'd0, OP_TEST = 4'd2, OP_NOP = 4'd15
	} pat_op_i0_e;

	typedef enum logic [1:0] {
		COND_Z = 2'd0, COND_NZ = 2'd1, COND_N = 2'd2, COND_AL = 2'd3
	} pat_cond_e;

	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_NOT, ALU_ADD, ALU_SUB,
		ALU_PASS,                              // b straight through, LDI and IN
		ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_ASR
	} pat_alu_op_e;

	// where a micro-op commits
	typedef enum logic [2:0] {
		DST_NONE, DST_REG, DST_FIELD, DST_OUT, DST_BRANCH, DST_FLAGS, DST_BUFSEL
	} pat_dest_e;

	typedef struct packed {
		pat_alu_op_e         alu_op;
		pat_dest_e           dest;
		logic [REG_AW-1:0]   rn;
		logic [FIELDP_W-1:0] fieldp;
		pat_cond_e           cond;
		logic                field_op;
		logic [PC_W-1:0]     pc;    // address of this instruction
		logic [7:0]          imm8;  // branch offset and buffer select
	} pat_uop_t;

endpackage
